// ==== hw/imem_pkg.sv ====
`default_nettype none

package imem_pkg;

    // word-interleaved banks with bank = word address mod 4
    localparam int NUM_BANKS  = 4;
    localparam int BANK_W     = $clog2(NUM_BANKS);
    localparam int BANK_DEPTH = 256;
    localparam int ROW_W      = 8;
    localparam int WORD_W     = 32;

    // byte address width covering the whole image
    localparam int IMG_AW = ROW_W + BANK_W + 2;
    localparam int APB_AW = 32;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } bank_rsp_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [WORD_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic [WORD_W-1:0] prdata;
        logic              pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/ifu_pkg.sv ====
`default_nettype none

package ifu_pkg;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;
    localparam int PC_STEP = 4;

    // packet queue toward decode
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [XLEN-1:0] pc_t;

    typedef enum logic [1:0] {
        redir_none,
        redir_jump_imm,
        redir_jump_reg,
        redir_trap
    } redirect_kind_t;

    typedef struct packed {
        logic            jal;
        logic            branch;
        logic            jalr;
        logic            trap;
        logic [XLEN-1:0] alu_res;
        pc_t             base_pc;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] r1;
        pc_t             mtvec;
    } redirect_t;

    typedef struct packed {
        logic                        valid;
        logic [imem_pkg::BANK_W-1:0] bank;
        logic [imem_pkg::ROW_W-1:0]  row;
        logic                        epoch;
        pc_t                         pc;
    } fetch_req_t;

    typedef struct packed {
        pc_t                         pc;
        logic [imem_pkg::WORD_W-1:0] inst;
    } fetch_pkt_t;

endpackage

`default_nettype wire

// ==== hw/apb_loader.sv ====
`default_nettype none

module apb_loader (
    input  wire logic                                                clk,
    input  wire logic                                                reset_i,
    input  wire imem_pkg::apb_req_t                                  apb_req_i,
    input  wire logic                                                run_i,
    input  wire logic [imem_pkg::NUM_BANKS-1:0][imem_pkg::WORD_W-1:0] rd_data_i,
    output imem_pkg::apb_rsp_t                                       apb_rsp_o,
    output logic [imem_pkg::NUM_BANKS-1:0]                           wr_en_o,
    output logic [imem_pkg::ROW_W-1:0]                               wr_row_o,
    output logic [imem_pkg::WORD_W-1:0]                              wr_data_o,
    output logic [imem_pkg::ROW_W-1:0]                               rd_row_o
);
    import imem_pkg::*;

    logic              setup;
    logic              access;
    logic              bad_addr;
    logic              err_q;
    logic              err;
    logic [BANK_W-1:0] bank_q;
    logic [ROW_W-1:0]  row_q;

    assign setup    = apb_req_i.psel && !apb_req_i.penable;
    assign access   = apb_req_i.psel && apb_req_i.penable;
    assign bad_addr = apb_req_i.paddr[APB_AW-1:IMG_AW] != '0;

    // address decoded in setup phase and held for the access phase
    always_ff @(posedge clk) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else if (setup) begin
            err_q <= run_i || bad_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            bank_q <= apb_req_i.paddr[BANK_W+1:2];
            row_q  <= apb_req_i.paddr[IMG_AW-1:BANK_W+2];
        end
    end

    // run may have gone high between setup and access
    assign err = err_q || run_i;

    always_comb begin
        wr_en_o = '0;
        if (access && apb_req_i.pwrite && !err) begin
            wr_en_o[bank_q] = 1'b1;
        end
    end

    assign wr_row_o  = row_q;
    assign wr_data_o = apb_req_i.pwdata;
    assign rd_row_o  = row_q;

    // no wait states
    assign apb_rsp_o.pready  = access;
    assign apb_rsp_o.pslverr = access && err;
    assign apb_rsp_o.prdata  = (access && !apb_req_i.pwrite && !err) ? rd_data_i[bank_q] : '0;

endmodule

`default_nettype wire

// ==== hw/pc_sequencer.sv ====
`default_nettype none

module pc_sequencer (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               run_i,
    input  wire ifu_pkg::redirect_t redirect_i,
    input  wire logic               room_i,
    output ifu_pkg::fetch_req_t     req_o,
    output logic                    epoch_o
);
    import ifu_pkg::*;
    import imem_pkg::*;

    pc_t            pc_q;
    logic           epoch_q;
    redirect_kind_t kind;
    pc_t            target;
    pc_t            jr_sum;
    pc_t            offset;
    logic           redirect;
    logic           issue;

    assign jr_sum = redirect_i.r1 + redirect_i.imm;

    // jal or taken branch wins, then jalr, then trap
    always_comb begin
        kind   = redir_none;
        target = pc_q;
        if (redirect_i.jal || (redirect_i.branch && redirect_i.alu_res == '0)) begin
            kind   = redir_jump_imm;
            target = redirect_i.base_pc + redirect_i.imm;
        end else if (redirect_i.jalr) begin
            kind   = redir_jump_reg;
            target = {jr_sum[XLEN-1:1], 1'b0};
        end else if (redirect_i.trap) begin
            kind   = redir_trap;
            target = redirect_i.mtvec;
        end
    end

    assign redirect = kind != redir_none;

    // no issue in a redirect cycle since the pc is being replaced
    assign issue = run_i && !redirect && room_i;

    // image is based at RESET_PC with the same layout as the APB word address
    assign offset = pc_q - RESET_PC;

    always_comb begin
        req_o       = '0;
        req_o.valid = issue;
        req_o.bank  = offset[BANK_W+1:2];
        req_o.row   = offset[IMG_AW-1:BANK_W+2];
        req_o.epoch = epoch_q;
        req_o.pc    = pc_q;
    end

    // collector sees the new epoch already in the redirect cycle
    assign epoch_o = epoch_q ^ redirect;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q    <= RESET_PC;
            epoch_q <= 1'b0;
        end else if (redirect) begin
            pc_q    <= target;
            epoch_q <= ~epoch_q;
        end else if (issue) begin
            pc_q <= pc_q + PC_STEP;
        end
    end

endmodule

`default_nettype wire

// ==== hw/imem_bank.sv ====
`default_nettype none

module imem_bank #(
    parameter logic [imem_pkg::BANK_W-1:0] BANK_ID = '0
) (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire ifu_pkg::fetch_req_t         req_i,
    input  wire logic                        wr_en_i,
    input  wire logic [imem_pkg::ROW_W-1:0]  wr_row_i,
    input  wire logic [imem_pkg::WORD_W-1:0] wr_data_i,
    input  wire logic [imem_pkg::ROW_W-1:0]  rd_row_i,
    output imem_pkg::bank_rsp_t              rsp_o,
    output logic [imem_pkg::WORD_W-1:0]      rd_data_o
);
    import imem_pkg::*;

    logic [WORD_W-1:0] mem [BANK_DEPTH];
    logic              hit;
    logic              valid_q;
    logic [WORD_W-1:0] data_q;

    // only requests for this bank
    assign hit = req_i.valid && (req_i.bank == BANK_ID);

    // loader write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_row_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            data_q <= mem[req_i.row];
        end
    end

    assign rsp_o = '{valid: valid_q, data: data_q};

    // asynchronous read-back for APB reads
    assign rd_data_o = mem[rd_row_i];

endmodule

`default_nettype wire

// ==== hw/fetch_collect.sv ====
`default_nettype none

module fetch_collect (
    input  wire logic                                       clk,
    input  wire logic                                       reset_i,
    input  wire ifu_pkg::fetch_req_t                        req_i,
    input  wire logic                                       epoch_i,
    input  wire imem_pkg::bank_rsp_t [imem_pkg::NUM_BANKS-1:0] rsp_i,
    input  wire logic                                       out_ready_i,
    output logic                                            room_o,
    output ifu_pkg::fetch_pkt_t                             out_pkt_o,
    output logic                                            out_valid_o
);
    import ifu_pkg::*;
    import imem_pkg::*;

    fetch_req_t            fly_q;
    logic                  seen_epoch_q;
    bank_rsp_t             rsp_sel;
    logic                  flush;
    logic                  push;
    logic                  pop;
    fetch_pkt_t            fifo_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W:0]   count_q;
    logic [FIFO_PTR_W:0]   free;

    // shadow of the request whose bank read is under way
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fly_q        <= '0;
            seen_epoch_q <= 1'b0;
        end else begin
            fly_q        <= req_i;
            seen_epoch_q <= epoch_i;
        end
    end

    assign rsp_sel = rsp_i[fly_q.bank];

    // stale words from before a redirect are dropped here
    assign push  = fly_q.valid && rsp_sel.valid && (fly_q.epoch == epoch_i);
    assign flush = epoch_i != seen_epoch_q;
    assign pop   = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= '{pc: fly_q.pc, inst: rsp_sel.data};
        end
    end

    assign out_valid_o = count_q != '0;
    assign out_pkt_o   = fifo_q[rd_ptr_q];

    // keep a slot for the word still in the bank
    assign free   = (FIFO_PTR_W + 1)'(FIFO_DEPTH) - count_q;
    assign room_o = free > (FIFO_PTR_W + 1)'(fly_q.valid);

endmodule

`default_nettype wire

// ==== hw/ifetch_top.sv ====
`default_nettype none

module ifetch_top (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               run_i,
    input  wire ifu_pkg::redirect_t redirect_i,
    input  wire imem_pkg::apb_req_t apb_req_i,
    output imem_pkg::apb_rsp_t      apb_rsp_o,
    output ifu_pkg::fetch_pkt_t     out_pkt_o,
    output logic                    out_valid_o,
    input  wire logic               out_ready_i
);
    import ifu_pkg::*;
    import imem_pkg::*;

    fetch_req_t                       req;
    logic                             epoch;
    logic                             room;
    bank_rsp_t [NUM_BANKS-1:0]        bank_rsp;
    logic [NUM_BANKS-1:0][WORD_W-1:0] rd_data;
    logic [NUM_BANKS-1:0]             wr_en;
    logic [ROW_W-1:0]                 wr_row;
    logic [ROW_W-1:0]                 rd_row;
    logic [WORD_W-1:0]                wr_data;

    pc_sequencer seq_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .run_i      (run_i),
        .redirect_i (redirect_i),
        .room_i     (room),
        .req_o      (req),
        .epoch_o    (epoch)
    );

    // one bank per word lane
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        imem_bank #(
            .BANK_ID (BANK_W'(b))
        ) bank_i (
            .clk       (clk),
            .reset_i   (reset_i),
            .req_i     (req),
            .wr_en_i   (wr_en[b]),
            .wr_row_i  (wr_row),
            .wr_data_i (wr_data),
            .rd_row_i  (rd_row),
            .rsp_o     (bank_rsp[b]),
            .rd_data_o (rd_data[b])
        );
    end

    fetch_collect collect_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (req),
        .epoch_i     (epoch),
        .rsp_i       (bank_rsp),
        .out_ready_i (out_ready_i),
        .room_o      (room),
        .out_pkt_o   (out_pkt_o),
        .out_valid_o (out_valid_o)
    );

    apb_loader loader_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .apb_req_i (apb_req_i),
        .run_i     (run_i),
        .rd_data_i (rd_data),
        .apb_rsp_o (apb_rsp_o),
        .wr_en_o   (wr_en),
        .wr_row_o  (wr_row),
        .wr_data_o (wr_data),
        .rd_row_o  (rd_row)
    );

endmodule

`default_nettype wire

// ==== testbench/ifetch_asserts.sv ====
`default_nettype none

module ifetch_asserts (
    input wire logic                          clk,
    input wire logic                          reset_i,
    input wire logic                          out_valid_i,
    input wire logic                          out_ready_i,
    input wire ifu_pkg::fetch_pkt_t           out_pkt_i,
    input wire logic                          flush_i,
    input wire logic [ifu_pkg::FIFO_PTR_W:0]  count_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import ifu_pkg::*;

    // decode sees nothing right after reset
    a_idle_after_reset: assert property (@(posedge clk) reset_i |=> !out_valid_i)
        else $error("out_valid_o high on the cycle after reset");

    // a stalled packet holds until taken unless a redirect flushes the queue
    a_pkt_stable: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && $stable(out_pkt_i))
        else $error("stalled packet changed or dropped before it was accepted");

    // room has to stop issue before words in flight overfill the queue
    a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
        count_i <= (FIFO_PTR_W + 1)'(FIFO_DEPTH))
        else $error("packet queue holds more entries than its depth");

endmodule

bind fetch_collect ifetch_asserts asserts_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_pkt_i   (out_pkt_o),
    .flush_i     (flush),
    .count_i     (count_q)
);

`default_nettype wire

// ==== testbench/ifetch_tb.sv ====
`default_nettype none

module ifetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ifu_pkg::*;
    import imem_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 15807;
    localparam int IMG_WORDS    = NUM_BANKS * BANK_DEPTH;
    localparam int SEQ_PKTS     = 32;
    localparam int BP_PKTS      = 64;
    localparam int REDIR_PKTS   = 8;
    localparam int NUM_REDIR    = 9;
    localparam int PKT_WAIT     = 8;

    // targets worked out by hand for base 0x200, imm -0x40, r1 0x301, mtvec 0x3c0
    localparam pc_t IMM_TARGET  = 64'h0000_0000_8000_01c0;
    localparam pc_t JALR_TARGET = 64'h0000_0000_8000_02c0;
    localparam pc_t TRAP_TARGET = 64'h0000_0000_8000_03c0;

    // rough length of each test in cycles
    localparam int APB_CYCLES   = 4 * IMG_WORDS + 16 + RESET_CYCLES;
    localparam int SEQ_CYCLES   = RESET_CYCLES + SEQ_PKTS + 4;
    localparam int BP_CYCLES    = RESET_CYCLES + 4 * BP_PKTS;
    localparam int REDIR_CYCLES = RESET_CYCLES + 8 + NUM_REDIR * (REDIR_PKTS + 12);
    localparam int TEST_CYCLES  = RESET_CYCLES + APB_CYCLES + SEQ_CYCLES + BP_CYCLES
                                  + REDIR_CYCLES;

    logic       clk;
    logic       reset;
    logic       run;
    redirect_t  redirect;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    fetch_pkt_t out_pkt;
    logic       out_valid;
    logic       out_ready;

    logic [WORD_W-1:0] image [IMG_WORDS];
    pc_t               last_pc;

    ifetch_top dut_i (
        .clk         (clk),
        .reset_i     (reset),
        .run_i       (run),
        .redirect_i  (redirect),
        .apb_req_i   (apb_req),
        .apb_rsp_o   (apb_rsp),
        .out_pkt_o   (out_pkt),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pkt(input string name, input fetch_pkt_t got,
                             input fetch_pkt_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got pc=%h inst=%h, expected pc=%h inst=%h",
                     name, got.pc, got.inst, exp.pc, exp.inst);
            abort_run();
        end
    endtask

    task automatic check_apb_rsp(input string name, input apb_rsp_t got,
                                 input apb_rsp_t exp);
        if (got.pready !== exp.pready || got.pslverr !== exp.pslverr) begin
            $display("FAILED %s: got pready=%h pslverr=%h, expected pready=%h pslverr=%h",
                     name, got.pready, got.pslverr, exp.pready, exp.pslverr);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // image word at pc where bank and row follow from the word address
    function automatic fetch_pkt_t expect_pkt(input pc_t pc);
        pc_t        offset;
        fetch_pkt_t pkt;
        offset   = pc - RESET_PC;
        pkt.pc   = pc;
        pkt.inst = image[offset[11:2]];
        return pkt;
    endfunction

    function automatic apb_rsp_t apb_status(input logic err);
        apb_rsp_t rsp;
        rsp         = '0;
        rsp.pready  = 1'b1;
        rsp.pslverr = err;
        return rsp;
    endfunction

    task automatic apply_reset();
        reset     = 1'b1;
        run       = 1'b0;
        out_ready = 1'b0;
        redirect  = '0;
        apb_req   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        if (out_valid || apb_rsp.pslverr) begin
            $display("out_valid_o or pslverr high during reset");
            abort_run();
        end
        reset = 1'b0;
    endtask

    // setup then access phase entered just after a rising edge
    task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                              input logic [WORD_W-1:0] wdata, output apb_rsp_t rsp);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rsp = apb_rsp;
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req = '0;
    endtask

    // counts transfers at the falling edge where valid and ready are settled
    task automatic accept_pkts(input int n, input pc_t first_pc, input bit random_ready);
        int got;
        int waited;
        got    = 0;
        waited = 0;
        while (got < n) begin
            out_ready = random_ready ? 1'($urandom) : 1'b1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                last_pc = first_pc + pc_t'(4 * got);
                check_pkt("out_pkt_o", out_pkt, expect_pkt(last_pc));
                got++;
            end
            waited++;
            if (waited > PKT_WAIT * n + 4) begin
                $display("packet stream stalled after %0d of %0d packets", got, n);
                abort_run();
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        out_ready = 1'b0;
    endtask

    task automatic load_and_verify_image();
        apb_rsp_t rsp;
        for (int i = 0; i < IMG_WORDS; i++) begin
            image[i] = $urandom;
            apb_access(1'b1, APB_AW'(i * 4), image[i], rsp);
            check_apb_rsp("apb write", rsp, apb_status(1'b0));
        end
        for (int i = 0; i < IMG_WORDS; i++) begin
            apb_access(1'b0, APB_AW'(i * 4), '0, rsp);
            check_apb_rsp("apb read", rsp, apb_status(1'b0));
            check_word("prdata", rsp.prdata, image[i]);
        end
        // first word past the image would alias onto word 0
        apb_access(1'b1, 32'h0000_1000, ~image[0], rsp);
        check_apb_rsp("apb write out of range", rsp, apb_status(1'b1));
        apb_access(1'b0, 32'h0000_1000, '0, rsp);
        check_apb_rsp("apb read out of range", rsp, apb_status(1'b1));
        run = 1'b1;
        apb_access(1'b1, 32'h0000_0004, ~image[1], rsp);
        check_apb_rsp("apb write while running", rsp, apb_status(1'b1));
        apb_access(1'b0, 32'h0000_0004, '0, rsp);
        check_apb_rsp("apb read while running", rsp, apb_status(1'b1));
        apply_reset();
        for (int i = 0; i < 2; i++) begin
            apb_access(1'b0, APB_AW'(i * 4), '0, rsp);
            check_word("prdata after rejected write", rsp.prdata, image[i]);
        end
    endtask

    task automatic verify_sequential_fetch();
        apply_reset();
        out_ready = 1'b1;
        run       = 1'b1;
        // first issue on the next edge and its packet one edge after that
        @(posedge clk);
        @(negedge clk);
        if (out_valid) begin
            $display("packet appeared one cycle after the first issue");
            abort_run();
        end
        @(posedge clk);
        for (int k = 0; k < SEQ_PKTS; k++) begin
            @(negedge clk);
            if (!out_valid) begin
                $display("packet %0d missing from the one per cycle stream", k);
                abort_run();
            end
            check_pkt("out_pkt_o", out_pkt, expect_pkt(RESET_PC + pc_t'(4 * k)));
            @(posedge clk);
        end
        #DRIVE_DELAY;
        out_ready = 1'b0;
    endtask

    task automatic drain_with_backpressure();
        apply_reset();
        run = 1'b1;
        accept_pkts(BP_PKTS, RESET_PC, 1'b1);
    endtask

    // kinds is {jal, branch, jalr, trap}
    task automatic redirect_case(input logic [3:0] kinds, input logic [XLEN-1:0] alu_res,
                                 input pc_t target, input int hold);
        redirect_t r;
        r                                = '0;
        {r.jal, r.branch, r.jalr, r.trap} = kinds;
        r.alu_res                        = alu_res;
        r.base_pc                        = RESET_PC + 64'h200;
        r.imm                            = -64'sd64;
        r.r1                             = RESET_PC + 64'h301;
        r.mtvec                          = TRAP_TARGET;
        // ready low lets words pile up in flight and in the queue
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        redirect = r;
        @(posedge clk);
        #DRIVE_DELAY;
        redirect = '0;
        accept_pkts(REDIR_PKTS, target, 1'b0);
    endtask

    task automatic exercise_redirects();
        apply_reset();
        run = 1'b1;
        accept_pkts(4, RESET_PC, 1'b0);
        redirect_case(4'b1000, 64'd0, IMM_TARGET, 1);
        // hold of 8 leaves the queue full of old words
        redirect_case(4'b0100, 64'd0, IMM_TARGET, 8);
        redirect_case(4'b0100, 64'd5, last_pc + 64'd4, 2);
        // r1 + imm is odd here
        redirect_case(4'b0010, 64'd0, JALR_TARGET, 8);
        redirect_case(4'b0001, 64'd0, TRAP_TARGET, 1);
        redirect_case(4'b1111, 64'd5, IMM_TARGET, 3);
        redirect_case(4'b0111, 64'd0, IMM_TARGET, 2);
        redirect_case(4'b0111, 64'd5, JALR_TARGET, 8);
        redirect_case(4'b0101, 64'd5, TRAP_TARGET, 1);
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial begin
        void'($urandom(SEED));
        clk       = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        redirect  = '0;
        apb_req   = '0;
        out_ready = 1'b0;
        last_pc   = RESET_PC;
        apply_reset();
        load_and_verify_image();
        verify_sequential_fetch();
        drain_with_backpressure();
        exercise_redirects();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/imem_pkg.sv
hw/ifu_pkg.sv
hw/apb_loader.sv
hw/pc_sequencer.sv
hw/imem_bank.sv
hw/fetch_collect.sv
hw/ifetch_top.sv
testbench/ifetch_asserts.sv
testbench/ifetch_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= ifetch_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps -Wno-fatal
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

SOURCES := $(shell cat $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation did not finish, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
